//--- rtl/fe_config.svh
`ifndef FE_CONFIG_SVH
`define FE_CONFIG_SVH

// first instruction fetched after reset
`define FE_RESET_PC     32'h1c00_0000

// sequential fetch step, one word
`define FE_PC_STEP      32'd4

// csr numbers as in the loongarch privileged spec
`define FE_CSR_ESTAT    14'h005
`define FE_CSR_ERA      14'h006
`define FE_CSR_BADV     14'h007
`define FE_CSR_EENTRY   14'h00c

// ecode field position inside estat
`define FE_ESTAT_ECODE_MSB  21
`define FE_ESTAT_ECODE_LSB  16

`endif

//--- rtl/isa_pkg.sv
package isa_pkg;

    // major opcode, bits 31:26 of every word
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,     // syscall lives here
        OP_PRIV    = 6'h01,     // ertn lives here
        OP_B       = 6'h14,
        OP_BL      = 6'h15
    } opcode_e;

    // full words of the two system instructions, syscall with code 0
    localparam logic [31:0] SYSCALL_WORD = 32'h002b_0000;
    localparam logic [31:0] ERTN_WORD    = 32'h0648_3800;

    // ecode values written to estat on an exception
    typedef enum logic [5:0] {
        ECODE_ADE = 6'h08,
        ECODE_SYS = 6'h0b
    } ecode_e;

    // register form, used to pick out syscall and ertn
    typedef struct packed {
        opcode_e     opcode;
        logic [15:0] imm16;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } reg_form_t;

    // long offset form of b and bl
    // offs[15:0] sits above offs[25:16] in the word
    typedef struct packed {
        opcode_e     opcode;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } long_offset_t;

    typedef union packed {
        reg_form_t    reg_form;
        long_offset_t long_offset;
    } inst_word_t;

endpackage

//--- rtl/frontend_pkg.sv
package frontend_pkg;

    // fetch to decode, 65 bits
    typedef struct packed {
        logic               adef;       // fetch pc was misaligned
        isa_pkg::inst_word_t inst;
        logic [31:0]        pc;
    } fs_to_ds_bus_t;

    // decode to fetch, 34 bits
    typedef struct packed {
        logic        cancel;    // instruction entering decode is dropped
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    // decode to execute
    typedef struct packed {
        logic [31:0]         pc;
        isa_pkg::inst_word_t inst;
        logic                link;          // bl writes r1
        logic [31:0]         link_value;
    } ds_to_es_bus_t;

    // decode to csr block, strobes last one cycle
    typedef struct packed {
        logic             ex;
        logic             ertn;
        isa_pkg::ecode_e  ecode;
        logic [31:0]      pc;
        logic [31:0]      badv;
    } ex_info_t;

    // csr block to fetch
    typedef struct packed {
        logic        ex;
        logic        ertn;
        logic [31:0] eentry;
        logic [31:0] era;
    } redirect_t;

endpackage

//--- rtl/if_stage.sv
`timescale 1ns/100ps
`include "fe_config.svh"

module if_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        ds_allowin,
    input  frontend_pkg::br_bus_t       br_bus,
    input  frontend_pkg::redirect_t     redirect,
    output logic                        sram_en,
    output logic [31:0]                 sram_addr,
    input  logic [31:0]                 sram_rdata,
    output logic                        fs_to_ds_valid,
    output frontend_pkg::fs_to_ds_bus_t fs_to_ds_bus
);
    import isa_pkg::*;

    logic        fs_valid;
    logic        fs_allowin;
    logic [31:0] fs_pc;
    logic [31:0] seq_pc;
    logic [31:0] nextpc;
    logic        hold_valid;
    inst_word_t  hold_inst;
    inst_word_t  fs_inst;

    // pre-if, next pc selection
    assign seq_pc = fs_pc + `FE_PC_STEP;

    always_comb begin
        if (redirect.ex) begin
            nextpc = redirect.eentry;
        end else if (redirect.ertn) begin
            nextpc = redirect.era;
        end else if (br_bus.taken) begin
            nextpc = br_bus.target;
        end else begin
            nextpc = seq_pc;
        end
    end

    assign fs_allowin = !fs_valid || ds_allowin;

    // read is issued on the edge fs loads the new pc
    assign sram_en   = fs_allowin && !reset;
    assign sram_addr = nextpc;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= `FE_RESET_PC - `FE_PC_STEP;   // so the first nextpc is the reset pc
        end else if (fs_allowin) begin
            fs_pc <= nextpc;
        end
    end

    // sram data is only good for one cycle, keep it while decode is full
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (fs_allowin) begin
            hold_valid <= 1'b0;
        end else if (!hold_valid) begin
            hold_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!fs_allowin && !hold_valid) begin
            hold_inst <= sram_rdata;    // first stalled cycle
        end
    end

    assign fs_inst = hold_valid ? hold_inst : inst_word_t'(sram_rdata);

    assign fs_to_ds_valid    = fs_valid;
    assign fs_to_ds_bus.adef = |fs_pc[1:0];
    assign fs_to_ds_bus.inst = fs_inst;
    assign fs_to_ds_bus.pc   = fs_pc;

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/100ps
`include "fe_config.svh"

module id_stage (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        fs_to_ds_valid,
    input  frontend_pkg::fs_to_ds_bus_t fs_to_ds_bus,
    output logic                        ds_allowin,
    output frontend_pkg::br_bus_t       br_bus,
    output frontend_pkg::ex_info_t      ex_info,
    input  logic                        es_allowin,
    output logic                        ds_to_es_valid,
    output frontend_pkg::ds_to_es_bus_t ds_to_es_bus
);
    import isa_pkg::*;
    import frontend_pkg::*;

    logic          ds_valid;
    fs_to_ds_bus_t ds_bus;
    logic          ds_go;
    logic          is_adef;
    logic          is_b;
    logic          is_bl;
    logic          is_syscall;
    logic          is_ertn;
    logic          is_trap;
    logic [25:0]   offs26;
    logic [31:0]   br_offs;
    logic          br_taken;
    logic          ex_pulse;
    logic          ertn_pulse;
    logic          redirect_any;

    assign ds_allowin = !ds_valid || es_allowin;
    assign ds_go      = ds_valid && es_allowin;     // instruction leaves decode

    // decode, nothing else is looked at once the fetch faulted
    assign is_adef = ds_bus.adef;

    assign is_b  = !is_adef && (ds_bus.inst.long_offset.opcode == OP_B);
    assign is_bl = !is_adef && (ds_bus.inst.long_offset.opcode == OP_BL);

    // syscall code in the low 15 bits is ignored
    assign is_syscall = !is_adef
                        && (ds_bus.inst.reg_form.opcode == OP_SPECIAL)
                        && (ds_bus.inst.reg_form.imm16[15:5] == SYSCALL_WORD[25:15]);

    assign is_ertn = !is_adef
                     && (ds_bus.inst.reg_form.opcode == OP_PRIV)
                     && (ds_bus.inst.reg_form.imm16 == ERTN_WORD[25:10])
                     && (ds_bus.inst.reg_form.rj == ERTN_WORD[9:5])
                     && (ds_bus.inst.reg_form.rd == ERTN_WORD[4:0]);

    assign is_trap = is_adef || is_syscall || is_ertn;

    // target is pc + sext(offs26 << 2)
    assign offs26  = {ds_bus.inst.long_offset.offs_hi, ds_bus.inst.long_offset.offs_lo};
    assign br_offs = {{4{offs26[25]}}, offs26, 2'b00};

    assign br_taken     = ds_go && (is_b || is_bl);
    assign ex_pulse     = ds_go && (is_adef || is_syscall);
    assign ertn_pulse   = ds_go && is_ertn;
    assign redirect_any = br_taken || ex_pulse || ertn_pulse;

    assign br_bus.cancel = redirect_any;
    assign br_bus.taken  = br_taken;
    assign br_bus.target = ds_bus.pc + br_offs;

    assign ex_info.ex    = ex_pulse;
    assign ex_info.ertn  = ertn_pulse;
    assign ex_info.ecode = is_adef ? ECODE_ADE : ECODE_SYS;
    assign ex_info.pc    = ds_bus.pc;
    assign ex_info.badv  = ds_bus.pc;     // bad fetch address is the pc itself

    // the fall-through instruction arriving with a redirect is dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid && !br_bus.cancel;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_allowin && fs_to_ds_valid) begin
            ds_bus <= fs_to_ds_bus;
        end
    end

    // traps end here and never reach execute
    assign ds_to_es_valid = ds_valid && !is_trap;

    assign ds_to_es_bus.pc         = ds_bus.pc;
    assign ds_to_es_bus.inst       = ds_bus.inst;
    assign ds_to_es_bus.link       = is_bl;
    assign ds_to_es_bus.link_value = ds_bus.pc + `FE_PC_STEP;

endmodule

//--- rtl/csr_regs.sv
`timescale 1ns/100ps
`include "fe_config.svh"

module csr_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  frontend_pkg::ex_info_t  ex_info,
    input  logic                    csr_we,
    input  logic [13:0]             csr_num,
    input  logic [31:0]             csr_wdata,
    output logic [31:0]             csr_rdata,
    output frontend_pkg::redirect_t redirect
);
    import isa_pkg::*;

    logic [31:0] eentry;
    logic [31:0] era;
    logic [31:0] estat;
    logic [31:0] badv;

    always_ff @(posedge clk) begin
        if (reset) begin
            eentry <= 32'h0;
            era    <= 32'h0;
            estat  <= 32'h0;
            badv   <= 32'h0;
        end else begin
            // eentry is never touched by hardware
            if (csr_we && csr_num == `FE_CSR_EENTRY) begin
                eentry <= csr_wdata;
            end

            if (ex_info.ex) begin
                era <= ex_info.pc;
                estat[`FE_ESTAT_ECODE_MSB:`FE_ESTAT_ECODE_LSB] <= ex_info.ecode;
                if (ex_info.ecode == ECODE_ADE) begin
                    badv <= ex_info.badv;
                end
            end else if (csr_we) begin
                case (csr_num)
                    `FE_CSR_ERA:   era   <= csr_wdata;
                    `FE_CSR_ESTAT: estat <= csr_wdata;
                    `FE_CSR_BADV:  badv  <= csr_wdata;
                    default:       ;
                endcase
            end
        end
    end

    always_comb begin
        case (csr_num)
            `FE_CSR_EENTRY: csr_rdata = eentry;
            `FE_CSR_ERA:    csr_rdata = era;
            `FE_CSR_ESTAT:  csr_rdata = estat;
            `FE_CSR_BADV:   csr_rdata = badv;
            default:        csr_rdata = 32'h0;
        endcase
    end

    // fetch takes the new pc in the same cycle as the strobe
    assign redirect.ex     = ex_info.ex;
    assign redirect.ertn   = ex_info.ertn;
    assign redirect.eentry = eentry;
    assign redirect.era    = era;

endmodule

//--- rtl/frontend_top.sv
`timescale 1ns/100ps

module frontend_top (
    input  logic                        clk,
    input  logic                        reset,
    // instruction sram, one cycle read latency
    output logic                        sram_en,
    output logic [31:0]                 sram_addr,
    input  logic [31:0]                 sram_rdata,
    // execute stage
    input  logic                        es_allowin,
    output logic                        ds_to_es_valid,
    output frontend_pkg::ds_to_es_bus_t ds_to_es_bus,
    // csr access port
    input  logic                        csr_we,
    input  logic [13:0]                 csr_num,
    input  logic [31:0]                 csr_wdata,
    output logic [31:0]                 csr_rdata
);
    import frontend_pkg::*;

    logic          fs_to_ds_valid;
    fs_to_ds_bus_t fs_to_ds_bus;
    logic          ds_allowin;
    br_bus_t       br_bus;
    ex_info_t      ex_info;
    redirect_t     redirect;

    if_stage if_stage_i (
        .clk            (clk),
        .reset          (reset),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .redirect       (redirect),
        .sram_en        (sram_en),
        .sram_addr      (sram_addr),
        .sram_rdata     (sram_rdata),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus)
    );

    id_stage id_stage_i (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .ex_info        (ex_info),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus)
    );

    csr_regs csr_regs_i (
        .clk       (clk),
        .reset     (reset),
        .ex_info   (ex_info),
        .csr_we    (csr_we),
        .csr_num   (csr_num),
        .csr_wdata (csr_wdata),
        .csr_rdata (csr_rdata),
        .redirect  (redirect)
    );

endmodule

//--- verification/frontend_props.sv
`timescale 1ns/100ps
`include "fe_config.svh"

module frontend_props (
    input logic                        clk,
    input logic                        reset,
    input logic                        sram_en,
    input logic [31:0]                 sram_addr,
    input logic                        es_allowin,
    input logic                        ds_to_es_valid,
    input frontend_pkg::ds_to_es_bus_t ds_to_es_bus
);

    int unsigned fail_count = 0;    // failed assertions so far

    // an offer refused by execute stays up
    valid_held: assert property (
        @(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> ds_to_es_valid
    ) else begin
        fail_count++;
        $error("ds_to_es_valid dropped while execute stalled");
    end

    bus_held: assert property (
        @(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allowin |=> $stable(ds_to_es_bus)
    ) else begin
        fail_count++;
        $error("ds_to_es_bus changed while execute stalled");
    end

    // first read after reset goes to the reset pc
    sram_start: assert property (
        @(posedge clk) reset |=> reset || (sram_en && sram_addr == `FE_RESET_PC)
    ) else begin
        fail_count++;
        $error("first fetch after reset is not a read of the reset pc");
    end

endmodule

bind frontend_top frontend_props frontend_props_i (.*);

//--- verification/frontend_tb.sv
`timescale 1ns/100ps
`include "fe_config.svh"

module frontend_tb;
    import frontend_pkg::*;

    localparam int unsigned NUM_OUT    = 600;
    localparam int unsigned IDLE_LIMIT = 100;
    localparam logic [31:0] HANDLER_PC   = `FE_RESET_PC + 32'd800;   // word index 200
    localparam logic [31:0] SYSCALL_WORD = 32'h002b_0000;
    localparam logic [31:0] ERTN_WORD    = 32'h0648_3800;
    localparam logic [31:0] ECODE_MASK   = 32'h003f_0000;
    localparam logic [5:0]  EC_ADE       = 6'h08;
    localparam logic [5:0]  EC_SYS       = 6'h0b;

    typedef struct packed {
        logic        we;
        logic [13:0] num;
        logic [31:0] data;      // write data, or expected read value
        logic [31:0] mask;
    } csr_op_t;

    logic          clk;
    logic          reset;
    logic          sram_en;
    logic [31:0]   sram_addr;
    logic [31:0]   sram_rdata;
    logic          es_allowin;
    logic          ds_to_es_valid;
    ds_to_es_bus_t ds_to_es_bus;
    logic          csr_we;
    logic [13:0]   csr_num;
    logic [31:0]   csr_wdata;
    logic [31:0]   csr_rdata;

    logic [31:0] mem [256];
    int          step_words [256];  // words to the next pc, 1 unless a branch
    csr_op_t     ops [$];

    // reference model state
    logic [31:0] m_pc;
    logic [31:0] ret_pc;        // where the handler's ertn goes back to
    logic        eentry_bad;
    logic        trapped;
    logic [31:0] exp_era;
    logic [5:0]  exp_ecode;
    logic [31:0] exp_badv;

    frontend_top frontend_top_i (
        .clk            (clk),
        .reset          (reset),
        .sram_en        (sram_en),
        .sram_addr      (sram_addr),
        .sram_rdata     (sram_rdata),
        .es_allowin     (es_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .csr_we         (csr_we),
        .csr_num        (csr_num),
        .csr_wdata      (csr_wdata),
        .csr_rdata      (csr_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (sram_en) begin
            sram_rdata <= mem[sram_addr[9:2]];  // one cycle read latency
        end
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_assertions();
        if (frontend_top_i.frontend_props_i.fail_count != 0) begin
            $display("A bound assertion on the frontend failed, see the error above");
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
        end
    endtask

    function automatic logic [31:0] branch_word(input logic [5:0] op, input int words);
        logic [25:0] offs;
        offs = words[25:0];
        return {op, offs[15:0], offs[25:16]};   // offs_lo above offs_hi
    endfunction

    function automatic csr_op_t csr_write(input logic [13:0] num, input logic [31:0] data);
        return '{we: 1'b1, num: num, data: data, mask: 32'hffff_ffff};
    endfunction

    function automatic csr_op_t csr_read(input logic [13:0] num, input logic [31:0] exp,
                                         input logic [31:0] mask);
        return '{we: 1'b0, num: num, data: exp, mask: mask};
    endfunction

    // main program in words 0..191, handler at 200..208
    task automatic fill_program();
        int unsigned r;
        int          k;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {6'h0a, 26'($urandom)};    // filler, never a branch or trap
            step_words[i] = 1;
        end
        for (int i = 4; i < 191; i++) begin
            r = $urandom % 16;
            k = 1 + ($urandom % 6);
            if (i + k > 191) k = 191 - i;
            if (r == 0) begin
                mem[i] = branch_word(6'h14, k);
                step_words[i] = k;
            end else if (r == 1) begin
                mem[i] = branch_word(6'h15, k);
                step_words[i] = k;
            end else if (r == 2) begin
                mem[i] = SYSCALL_WORD;
            end
        end
        mem[191] = branch_word(6'h14, -191);    // back to the reset pc
        step_words[191] = -191;
        mem[208] = ERTN_WORD;
    endtask

    // walk the program until the next instruction that reaches execute
    task automatic model_next(output logic [31:0] pc, output logic [31:0] word,
                              output logic link);
        logic [31:0] w;
        logic        done;
        done = 1'b0;
        for (int n = 0; n < 8 && !done; n++) begin
            w = mem[m_pc[9:2]];
            if (m_pc[1:0] != 2'b00) begin
                exp_era   = m_pc;
                exp_ecode = EC_ADE;
                exp_badv  = m_pc;
                trapped   = 1'b1;
                m_pc      = HANDLER_PC;
            end else if (w == SYSCALL_WORD) begin
                exp_era   = m_pc;
                exp_ecode = EC_SYS;
                ret_pc    = m_pc + `FE_PC_STEP;
                trapped   = 1'b1;
                m_pc      = eentry_bad ? HANDLER_PC + 32'd2 : HANDLER_PC;
                eentry_bad = 1'b0;
            end else if (w == ERTN_WORD) begin
                m_pc = ret_pc;
            end else begin
                pc   = m_pc;
                word = w;
                link = (w[31:26] == 6'h15);
                m_pc = m_pc + `FE_PC_STEP * step_words[m_pc[9:2]];
                done = 1'b1;
            end
        end
    endtask

    initial begin
        int unsigned seed_ret;
        int unsigned outputs;
        int unsigned idle;
        int unsigned entries;
        csr_op_t     cur;
        logic        have_op;
        logic [31:0] pc;
        logic [31:0] word;
        logic        link;

        seed_ret   = $urandom(32'hea17dd34);
        reset      = 1'b1;
        es_allowin = 1'b1;
        csr_we     = 1'b0;
        csr_num    = 14'h0;
        csr_wdata  = 32'h0;
        sram_rdata = 32'h0;
        outputs    = 0;
        idle       = 0;
        entries    = 0;
        cur        = '0;
        m_pc       = `FE_RESET_PC;
        ret_pc     = `FE_RESET_PC;
        eentry_bad = 1'b0;
        trapped    = 1'b0;
        fill_program();
        ops.push_back(csr_write(`FE_CSR_EENTRY, HANDLER_PC));

        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        while (outputs < NUM_OUT) begin
            @(posedge clk);
            #2;
            es_allowin = ($urandom % 4) != 0;
            have_op    = ops.size() > 0;
            if (have_op) cur = ops.pop_front();
            csr_we    = have_op && cur.we;
            csr_num   = cur.num;
            csr_wdata = cur.data;

            @(negedge clk);
            check_assertions();
            if (have_op && !cur.we) begin
                check_value($sformatf("csr %0h", cur.num), csr_rdata & cur.mask, cur.data);
            end
            // misaligned entry fetched, fix eentry before the ade leaves decode
            if (sram_en && sram_addr == HANDLER_PC + 32'd2) begin
                ops.push_front(csr_write(`FE_CSR_EENTRY, HANDLER_PC));
            end
            if (ds_to_es_valid && es_allowin) begin
                model_next(pc, word, link);
                check_value("output pc", ds_to_es_bus.pc, pc);
                check_value("output inst", ds_to_es_bus.inst, word);
                check_value("link flag", 32'(ds_to_es_bus.link), 32'(link));
                if (link) check_value("link value", ds_to_es_bus.link_value, pc + 32'd4);
                outputs++;
                idle = 0;
                if (trapped) begin
                    trapped = 1'b0;
                    entries++;
                    ops.push_back(csr_read(`FE_CSR_ERA, exp_era, 32'hffff_ffff));
                    ops.push_back(csr_read(`FE_CSR_ESTAT, {10'h0, exp_ecode, 16'h0},
                                           ECODE_MASK));
                    if (exp_ecode == EC_ADE) begin
                        ops.push_back(csr_read(`FE_CSR_BADV, exp_badv, 32'hffff_ffff));
                    end
                    ops.push_back(csr_write(`FE_CSR_ERA, ret_pc));  // resume after syscall
                    if (entries % 3 == 1) begin
                        ops.push_back(csr_write(`FE_CSR_EENTRY, HANDLER_PC + 32'd2));
                        eentry_bad = 1'b1;
                    end
                end
            end else begin
                idle++;
                if (idle > IDLE_LIMIT) begin
                    $display("Timeout: no instruction reached execute for %0d cycles",
                             IDLE_LIMIT);
                    $display("TEST FAILED");
                    $fatal(1, "pipeline stopped");
                end
            end
        end

        // let the assertions see the last transfer edge
        @(negedge clk);
        if (frontend_top_i.frontend_props_i.fail_count != 0) begin
            $display("A bound assertion on the frontend failed, see the error above");
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- all.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/frontend_pkg.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/csr_regs.sv
rtl/frontend_top.sv
verification/frontend_props.sv
verification/frontend_tb.sv

//--- Bender.yml
package:
  name: frontend

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/isa_pkg.sv
      - rtl/frontend_pkg.sv
      - rtl/if_stage.sv
      - rtl/id_stage.sv
      - rtl/csr_regs.sv
      - rtl/frontend_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/frontend_props.sv
      - verification/frontend_tb.sv
